// ==== build.f ====
+incdir+design
design/array_mem_pkg.sv
design/memory_bus_if.sv
design/cpu_bus_bridge.sv
design/controller_regs.sv
design/mod_memory.sv
design/stm_memory.sv
design/array_mem_top.sv
verification/array_mem_tb.sv

// ==== build.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f build.f --top-module array_mem_tb -o array_mem_sim \
  && ./obj_dir/array_mem_sim | tee /dev/stderr | grep -x "test passed" > /dev/null \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

// ==== design/array_mem_config.svh ====
`ifndef ARRAY_MEM_CONFIG_SVH
`define ARRAY_MEM_CONFIG_SVH

// Modulation memory holds 256 words per segment
`define MOD_ADDR_BITS 8

// STM memory holds four pages of 256 words per segment
`define STM_ADDR_BITS 8
`define STM_PAGE_BITS 2

// Word width of the CPU bus and of the bank-relative word address
`define BUS_DATA_BITS 16
`define BUS_ADDR_BITS 14

// Controller bank, write-side registers
`define ADDR_MOD_MEM_WR_SEGMENT 14'h0000
`define ADDR_STM_MEM_WR_SEGMENT 14'h0001
`define ADDR_STM_MEM_WR_PAGE 14'h0002

// Controller bank, modulation read-side settings
`define ADDR_MOD_REQ_RD_SEGMENT 14'h0010
`define ADDR_MOD_CYCLE 14'h0011

// Controller bank, STM read-side settings
`define ADDR_STM_REQ_RD_SEGMENT 14'h0020
`define ADDR_STM_CYCLE 14'h0021
`define ADDR_STM_MODE 14'h0022

`endif

// ==== design/array_mem_pkg.sv ====
`include "array_mem_config.svh"

package array_mem_pkg;

  // One CPU data word
  typedef logic [`BUS_DATA_BITS-1:0] bus_word_t;

  // Word address inside the selected bank
  typedef logic [`BUS_ADDR_BITS-1:0] bus_addr_t;

  // Bank select from cpu_addr[16:15]
  // Code 2 belongs to the duty table, which this front end does not implement
  typedef enum logic [1:0] {
    bank_controller = 2'd0,
    bank_mod        = 2'd1,
    bank_stm        = 2'd3
  } bank_sel_t;

  // Modulation word index inside one segment
  typedef logic [`MOD_ADDR_BITS-1:0] mod_idx_t;

  // STM word index inside one page
  typedef logic [`STM_ADDR_BITS-1:0] stm_idx_t;

  // STM page number inside one segment
  typedef logic [`STM_PAGE_BITS-1:0] stm_page_t;

  // Double-buffer segment number
  typedef logic segment_t;

endpackage

// ==== design/array_mem_top.sv ====
`timescale 1ns/1ps

module array_mem_top (
  input  logic                     CPU_CKIO,
  input  logic                     rst_n,
  input  logic [16:0]              cpu_addr,
  input  array_mem_pkg::bus_word_t cpu_data_in,
  output array_mem_pkg::bus_word_t cpu_data_out,
  input  logic                     cpu_cs1_n,
  input  logic                     cpu_we0_n,
  input  array_mem_pkg::segment_t  mod_rd_segment,
  input  array_mem_pkg::mod_idx_t  mod_rd_idx,
  output array_mem_pkg::bus_word_t mod_rd_data,
  input  array_mem_pkg::segment_t  stm_rd_segment,
  input  array_mem_pkg::stm_page_t stm_rd_page,
  input  array_mem_pkg::stm_idx_t  stm_rd_idx,
  output array_mem_pkg::bus_word_t stm_rd_data,
  output array_mem_pkg::segment_t  mod_req_rd_segment,
  output array_mem_pkg::bus_word_t mod_cycle,
  output array_mem_pkg::segment_t  stm_req_rd_segment,
  output array_mem_pkg::bus_word_t stm_cycle,
  output logic                     stm_mode
);

  array_mem_pkg::segment_t  mod_wr_segment;
  array_mem_pkg::segment_t  stm_wr_segment;
  array_mem_pkg::stm_page_t stm_wr_page;

  memory_bus_if bus ();

  cpu_bus_bridge i_cpu_bus_bridge (
    .CPU_CKIO   (CPU_CKIO),
    .rst_n      (rst_n),
    .cpu_addr   (cpu_addr),
    .cpu_data_in(cpu_data_in),
    .cpu_cs1_n  (cpu_cs1_n),
    .cpu_we0_n  (cpu_we0_n),
    .bus        (bus.bridge)
  );

  controller_regs i_controller_regs (
    .CPU_CKIO          (CPU_CKIO),
    .rst_n             (rst_n),
    .bus               (bus.target),
    .rdata             (cpu_data_out),
    .mod_wr_segment    (mod_wr_segment),
    .stm_wr_segment    (stm_wr_segment),
    .stm_wr_page       (stm_wr_page),
    .mod_req_rd_segment(mod_req_rd_segment),
    .stm_req_rd_segment(stm_req_rd_segment),
    .mod_cycle         (mod_cycle),
    .stm_cycle         (stm_cycle),
    .stm_mode          (stm_mode)
  );

  mod_memory i_mod_memory (
    .CPU_CKIO  (CPU_CKIO),
    .rst_n     (rst_n),
    .bus       (bus.target),
    .wr_segment(mod_wr_segment),
    .rd_segment(mod_rd_segment),
    .rd_idx    (mod_rd_idx),
    .rd_data   (mod_rd_data)
  );

  stm_memory i_stm_memory (
    .CPU_CKIO  (CPU_CKIO),
    .rst_n     (rst_n),
    .bus       (bus.target),
    .wr_segment(stm_wr_segment),
    .wr_page   (stm_wr_page),
    .rd_segment(stm_rd_segment),
    .rd_page   (stm_rd_page),
    .rd_idx    (stm_rd_idx),
    .rd_data   (stm_rd_data)
  );

endmodule

// ==== design/controller_regs.sv ====
`timescale 1ns/1ps
`include "array_mem_config.svh"

module controller_regs (
  input  logic                      CPU_CKIO,
  input  logic                      rst_n,
  memory_bus_if.target              bus,
  output array_mem_pkg::bus_word_t  rdata,
  output array_mem_pkg::segment_t   mod_wr_segment,
  output array_mem_pkg::segment_t   stm_wr_segment,
  output array_mem_pkg::stm_page_t  stm_wr_page,
  output array_mem_pkg::segment_t   mod_req_rd_segment,
  output array_mem_pkg::segment_t   stm_req_rd_segment,
  output array_mem_pkg::bus_word_t  mod_cycle,
  output array_mem_pkg::bus_word_t  stm_cycle,
  output logic                      stm_mode
);

  logic                     wr_ctl;
  array_mem_pkg::bus_word_t rd_word;

  assign wr_ctl = bus.wr && (bus.sel == array_mem_pkg::bank_controller);

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      mod_wr_segment     <= '0;
      stm_wr_segment     <= '0;
      stm_wr_page        <= '0;
      mod_req_rd_segment <= '0;
      stm_req_rd_segment <= '0;
      mod_cycle          <= '0;
      stm_cycle          <= '0;
      stm_mode           <= 1'b0;
    end else if (wr_ctl) begin
      case (bus.addr)
        `ADDR_MOD_MEM_WR_SEGMENT: mod_wr_segment <= bus.wdata[0];
        `ADDR_STM_MEM_WR_SEGMENT: stm_wr_segment <= bus.wdata[0];
        `ADDR_STM_MEM_WR_PAGE:    stm_wr_page <= bus.wdata[`STM_PAGE_BITS-1:0];
        `ADDR_MOD_REQ_RD_SEGMENT: mod_req_rd_segment <= bus.wdata[0];
        `ADDR_MOD_CYCLE:          mod_cycle <= bus.wdata;
        `ADDR_STM_REQ_RD_SEGMENT: stm_req_rd_segment <= bus.wdata[0];
        `ADDR_STM_CYCLE:          stm_cycle <= bus.wdata;
        `ADDR_STM_MODE:           stm_mode <= bus.wdata[0];
        default: ;
      endcase
    end
  end

  // Read-back mux, unmapped addresses read as zero
  always_comb begin
    rd_word = '0;
    case (bus.rd_addr)
      `ADDR_MOD_MEM_WR_SEGMENT: rd_word = array_mem_pkg::bus_word_t'(mod_wr_segment);
      `ADDR_STM_MEM_WR_SEGMENT: rd_word = array_mem_pkg::bus_word_t'(stm_wr_segment);
      `ADDR_STM_MEM_WR_PAGE:    rd_word = array_mem_pkg::bus_word_t'(stm_wr_page);
      `ADDR_MOD_REQ_RD_SEGMENT: rd_word = array_mem_pkg::bus_word_t'(mod_req_rd_segment);
      `ADDR_MOD_CYCLE:          rd_word = mod_cycle;
      `ADDR_STM_REQ_RD_SEGMENT: rd_word = array_mem_pkg::bus_word_t'(stm_req_rd_segment);
      `ADDR_STM_CYCLE:          rd_word = stm_cycle;
      `ADDR_STM_MODE:           rd_word = array_mem_pkg::bus_word_t'(stm_mode);
      default:                  rd_word = '0;
    endcase
  end

  // Only the controller bank can be read back by the host
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (bus.sel == array_mem_pkg::bank_controller) begin
      rdata <= rd_word;
    end else begin
      rdata <= '0;
    end
  end

endmodule

// ==== design/cpu_bus_bridge.sv ====
`timescale 1ns/1ps

module cpu_bus_bridge (
  input  logic                     CPU_CKIO,
  input  logic                     rst_n,
  input  logic [16:0]              cpu_addr,
  input  array_mem_pkg::bus_word_t cpu_data_in,
  input  logic                     cpu_cs1_n,
  input  logic                     cpu_we0_n,
  memory_bus_if.bridge             bus
);

  // First stage captures the asynchronous bus, bit 0 is a byte lane and is dropped
  logic [16:1]              addr_q;
  array_mem_pkg::bus_word_t data_q;
  logic                     cs_n_q;
  logic                     we_n_q;
  logic                     wen_q;
  logic                     wen_now;
  logic                     ren_now;

  assign wen_now = ~cs_n_q & ~we_n_q;
  assign ren_now = ~cs_n_q & we_n_q;

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
      cs_n_q <= 1'b1;
      we_n_q <= 1'b1;
    end else begin
      addr_q <= cpu_addr[16:1];
      cs_n_q <= cpu_cs1_n;
      we_n_q <= cpu_we0_n;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    data_q <= cpu_data_in;
  end

  // Second stage remembers the last qualified write enable so that only
  // the leading edge produces a write, however long WE0 stays low
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      wen_q       <= 1'b0;
      bus.wr      <= 1'b0;
      bus.sel     <= array_mem_pkg::bank_controller;
      bus.addr    <= '0;
      bus.rd_addr <= '0;
    end else begin
      wen_q    <= wen_now;
      bus.wr   <= wen_now & ~wen_q;
      bus.sel  <= array_mem_pkg::bank_sel_t'(addr_q[16:15]);
      bus.addr <= addr_q[14:1];
      if (ren_now) begin
        bus.rd_addr <= addr_q[14:1];
      end
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    bus.wdata <= data_q;
  end

  // A held WE0 must never turn into back-to-back writes
  a_wr_single_cycle : assert property (
    @(posedge CPU_CKIO) disable iff (!rst_n) bus.wr |=> !bus.wr
  ) else $error("bridge produced a write strobe on two consecutive cycles");

endmodule

// ==== design/memory_bus_if.sv ====
`timescale 1ns/1ps

interface memory_bus_if;

  // Single-cycle write strobe, already edge detected
  logic wr;
  array_mem_pkg::bank_sel_t sel;
  array_mem_pkg::bus_addr_t addr;
  array_mem_pkg::bus_word_t wdata;

  // Address of the word being read back, held while the host keeps reading
  array_mem_pkg::bus_addr_t rd_addr;

  modport bridge (
    output wr,
    output sel,
    output addr,
    output wdata,
    output rd_addr
  );

  modport target (
    input wr,
    input sel,
    input addr,
    input wdata,
    input rd_addr
  );

endinterface

// ==== design/mod_memory.sv ====
`timescale 1ns/1ps
`include "array_mem_config.svh"

module mod_memory (
  input  logic                     CPU_CKIO,
  input  logic                     rst_n,
  memory_bus_if.target             bus,
  input  array_mem_pkg::segment_t  wr_segment,
  input  array_mem_pkg::segment_t  rd_segment,
  input  array_mem_pkg::mod_idx_t  rd_idx,
  output array_mem_pkg::bus_word_t rd_data
);

  localparam int DEPTH = 2 << `MOD_ADDR_BITS;

  // Segment is the top address bit, so the host fills one half
  // while the output side plays the other
  array_mem_pkg::bus_word_t     mem [DEPTH];
  logic [`MOD_ADDR_BITS:0]      wr_ptr;
  logic [`MOD_ADDR_BITS:0]      rd_ptr;
  logic                         wr_en;

  assign wr_en  = bus.wr && (bus.sel == array_mem_pkg::bank_mod);
  assign wr_ptr = {wr_segment, bus.addr[`MOD_ADDR_BITS-1:0]};
  assign rd_ptr = {rd_segment, rd_idx};

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[wr_ptr] <= bus.wdata;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_data <= mem[rd_ptr];
  end

  // The host selects the segment through the controller bank,
  // so a word address beyond one segment would silently wrap
  a_mod_addr_in_segment : assert property (
    @(posedge CPU_CKIO) disable iff (!rst_n)
      wr_en |-> (bus.addr[`BUS_ADDR_BITS-1:`MOD_ADDR_BITS] == '0)
  ) else $error("modulation write address %0h lies outside one segment", bus.addr);

endmodule

// ==== design/stm_memory.sv ====
`timescale 1ns/1ps
`include "array_mem_config.svh"

module stm_memory (
  input  logic                     CPU_CKIO,
  input  logic                     rst_n,
  memory_bus_if.target             bus,
  input  array_mem_pkg::segment_t  wr_segment,
  input  array_mem_pkg::stm_page_t wr_page,
  input  array_mem_pkg::segment_t  rd_segment,
  input  array_mem_pkg::stm_page_t rd_page,
  input  array_mem_pkg::stm_idx_t  rd_idx,
  output array_mem_pkg::bus_word_t rd_data
);

  localparam int PTR_BITS = 1 + `STM_PAGE_BITS + `STM_ADDR_BITS;
  localparam int DEPTH    = 1 << PTR_BITS;

  // Each word packs intensity in the upper byte and phase in the lower byte
  array_mem_pkg::bus_word_t mem [DEPTH];
  logic [PTR_BITS-1:0]      wr_ptr;
  logic [PTR_BITS-1:0]      rd_ptr;
  logic                     wr_en;

  assign wr_en  = bus.wr && (bus.sel == array_mem_pkg::bank_stm);
  assign wr_ptr = {wr_segment, wr_page, bus.addr[`STM_ADDR_BITS-1:0]};
  assign rd_ptr = {rd_segment, rd_page, rd_idx};

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[wr_ptr] <= bus.wdata;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_data <= mem[rd_ptr];
  end

  // Pages are switched through the page register, never through the word address
  a_stm_addr_in_page : assert property (
    @(posedge CPU_CKIO) disable iff (!rst_n)
      wr_en |-> (bus.addr[`BUS_ADDR_BITS-1:`STM_ADDR_BITS] == '0)
  ) else $error("STM write address %0h exceeds one page", bus.addr);

endmodule

// ==== verification/array_mem_tb.sv ====
`timescale 1ns/1ps
`include "array_mem_config.svh"

module array_mem_tb;

  localparam int WRITE_CYCLES = 7;
  localparam int READ_CYCLES  = 5;
  localparam int TEST_CYCLES  = 20 + 32 * (WRITE_CYCLES + READ_CYCLES) + 1536 * (WRITE_CYCLES + 2);

  logic                     CPU_CKIO;
  logic                     rst_n;
  logic [16:0]              cpu_addr;
  array_mem_pkg::bus_word_t cpu_data_in;
  array_mem_pkg::bus_word_t cpu_data_out;
  logic                     cpu_cs1_n;
  logic                     cpu_we0_n;
  array_mem_pkg::segment_t  mod_rd_segment;
  array_mem_pkg::mod_idx_t  mod_rd_idx;
  array_mem_pkg::bus_word_t mod_rd_data;
  array_mem_pkg::segment_t  stm_rd_segment;
  array_mem_pkg::stm_page_t stm_rd_page;
  array_mem_pkg::stm_idx_t  stm_rd_idx;
  array_mem_pkg::bus_word_t stm_rd_data;
  array_mem_pkg::segment_t  mod_req_rd_segment;
  array_mem_pkg::bus_word_t mod_cycle;
  array_mem_pkg::segment_t  stm_req_rd_segment;
  array_mem_pkg::bus_word_t stm_cycle;
  logic                     stm_mode;

  int                       error_count;
  logic [31:0]              lfsr_state;
  array_mem_pkg::bus_word_t mod_model [512];
  array_mem_pkg::bus_word_t stm_model [1024];
  array_mem_pkg::bus_word_t mod_cycle_model;

  array_mem_top i_array_mem_top (.*);

  initial begin
    CPU_CKIO = 1'b0;
    forever #10 CPU_CKIO = ~CPU_CKIO;
  end

  // Galois LFSR, stepped once for every bit of the word
  function automatic array_mem_pkg::bus_word_t lfsr_word();
    array_mem_pkg::bus_word_t word;
    logic                     bit_out;
    word = '0;
    for (int i = 0; i < 16; i++) begin
      bit_out    = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (bit_out ? 32'h8020_0003 : 32'h0);
      word       = {word[14:0], bit_out};
    end
    return word;
  endfunction

  // Address, CS1 low, WE0 low for low_cycles, WE0 high, then CS1 high
  task automatic bus_write(input logic [1:0] bank, input array_mem_pkg::bus_addr_t word,
                           input array_mem_pkg::bus_word_t data, input int low_cycles);
    @(posedge CPU_CKIO);
    #2;
    cpu_addr    = {bank, word, 1'b0};
    cpu_data_in = data;
    cpu_cs1_n   = 1'b0;
    @(posedge CPU_CKIO);
    #2;
    cpu_we0_n = 1'b0;
    repeat (low_cycles) @(posedge CPU_CKIO);
    #2;
    cpu_we0_n = 1'b1;
    @(posedge CPU_CKIO);
    #2;
    cpu_cs1_n = 1'b1;
    repeat (2) @(posedge CPU_CKIO);
  endtask

  task automatic bus_read(input logic [1:0] bank, input array_mem_pkg::bus_addr_t word,
                          output array_mem_pkg::bus_word_t data);
    @(posedge CPU_CKIO);
    #2;
    cpu_addr  = {bank, word, 1'b0};
    cpu_cs1_n = 1'b0;
    cpu_we0_n = 1'b1;
    repeat (4) @(posedge CPU_CKIO);
    #2;
    data      = cpu_data_out;
    cpu_cs1_n = 1'b1;
  endtask

  // Both output-side read ports answer one cycle after the index
  task automatic read_ports(input array_mem_pkg::segment_t seg,
                            input array_mem_pkg::stm_page_t page,
                            input array_mem_pkg::mod_idx_t idx);
    @(posedge CPU_CKIO);
    #2;
    mod_rd_segment = seg;
    mod_rd_idx     = idx;
    stm_rd_segment = seg;
    stm_rd_page    = page;
    stm_rd_idx     = idx;
    @(posedge CPU_CKIO);
    #1;
  endtask

  task automatic check_word(input string test, input array_mem_pkg::bus_word_t expected,
                            input array_mem_pkg::bus_word_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("error %s: expected %h, actual %h", test, expected, actual);
    end
  endtask

  task automatic check_segment(input string test, input array_mem_pkg::segment_t expected,
                               input array_mem_pkg::segment_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("error %s: expected %h, actual %h", test, expected, actual);
    end
  endtask

  task automatic check_page(input string test, input array_mem_pkg::stm_page_t expected,
                            input array_mem_pkg::stm_page_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("error %s: expected %h, actual %h", test, expected, actual);
    end
  endtask

  task automatic test_reset_values();
    check_word("reset_values", '0, cpu_data_out);
    check_segment("reset_values", 1'b0, mod_req_rd_segment);
    check_word("reset_values", '0, mod_cycle);
    check_segment("reset_values", 1'b0, stm_req_rd_segment);
    check_word("reset_values", '0, stm_cycle);
    check_segment("reset_values", 1'b0, stm_mode);
  endtask

  task automatic write_and_read_reg(input array_mem_pkg::bus_addr_t addr,
                                    input array_mem_pkg::bus_word_t mask,
                                    output array_mem_pkg::bus_word_t expected);
    array_mem_pkg::bus_word_t data;
    array_mem_pkg::bus_word_t readback;
    // Top and bottom bits set so the register width always shows in the result
    data     = lfsr_word() | 16'h8001;
    expected = data & mask;
    bus_write(array_mem_pkg::bank_controller, addr, data, 2);
    bus_read(array_mem_pkg::bank_controller, addr, readback);
    check_word("controller_regs", expected, readback);
  endtask

  task automatic test_controller_regs();
    array_mem_pkg::bus_word_t wr_side;
    array_mem_pkg::bus_word_t mod_req;
    array_mem_pkg::bus_word_t stm_req;
    array_mem_pkg::bus_word_t stm_cyc;
    array_mem_pkg::bus_word_t mode;
    write_and_read_reg(`ADDR_MOD_MEM_WR_SEGMENT, 16'h0001, wr_side);
    write_and_read_reg(`ADDR_STM_MEM_WR_SEGMENT, 16'h0001, wr_side);
    write_and_read_reg(`ADDR_STM_MEM_WR_PAGE, 16'h0003, wr_side);
    write_and_read_reg(`ADDR_MOD_REQ_RD_SEGMENT, 16'h0001, mod_req);
    write_and_read_reg(`ADDR_MOD_CYCLE, 16'hffff, mod_cycle_model);
    write_and_read_reg(`ADDR_STM_REQ_RD_SEGMENT, 16'h0001, stm_req);
    write_and_read_reg(`ADDR_STM_CYCLE, 16'hffff, stm_cyc);
    write_and_read_reg(`ADDR_STM_MODE, 16'h0001, mode);
    check_segment("controller_outputs", mod_req[0], mod_req_rd_segment);
    check_word("controller_outputs", mod_cycle_model, mod_cycle);
    check_segment("controller_outputs", stm_req[0], stm_req_rd_segment);
    check_word("controller_outputs", stm_cyc, stm_cycle);
    check_segment("controller_outputs", mode[0], stm_mode);
  endtask

  task automatic test_mod_segments();
    array_mem_pkg::segment_t  seg;
    array_mem_pkg::mod_idx_t  idx;
    array_mem_pkg::bus_word_t data;
    for (int s = 0; s < 2; s++) begin
      bus_write(array_mem_pkg::bank_controller, `ADDR_MOD_MEM_WR_SEGMENT,
                array_mem_pkg::bus_word_t'(s), 2);
      for (int i = 0; i < 256; i++) begin
        {seg, idx} = 9'(s * 256 + i);
        data = lfsr_word();
        mod_model[{seg, idx}] = data;
        bus_write(array_mem_pkg::bank_mod, array_mem_pkg::bus_addr_t'(i), data, 2);
      end
    end
    for (int k = 0; k < 512; k++) begin
      {seg, idx} = 9'(k);
      read_ports(seg, 2'd0, idx);
      check_word("mod_segments", mod_model[{seg, idx}], mod_rd_data);
    end
  endtask

  task automatic test_stm_pages();
    array_mem_pkg::stm_page_t page;
    array_mem_pkg::stm_idx_t  idx;
    array_mem_pkg::bus_word_t data;
    array_mem_pkg::bus_word_t readback;
    bus_write(array_mem_pkg::bank_controller, `ADDR_STM_MEM_WR_SEGMENT, 16'h0000, 2);
    for (int p = 0; p < 4; p++) begin
      page = array_mem_pkg::stm_page_t'(p);
      bus_write(array_mem_pkg::bank_controller, `ADDR_STM_MEM_WR_PAGE,
                array_mem_pkg::bus_word_t'(p), 2);
      bus_read(array_mem_pkg::bank_controller, `ADDR_STM_MEM_WR_PAGE, readback);
      check_page("stm_pages", page, array_mem_pkg::stm_page_t'(readback));
      for (int i = 0; i < 256; i++) begin
        idx  = array_mem_pkg::stm_idx_t'(i);
        data = lfsr_word();
        stm_model[{page, idx}] = data;
        bus_write(array_mem_pkg::bank_stm, array_mem_pkg::bus_addr_t'(i), data, 2);
      end
    end
    // Page 0 is read last of all, long after the other pages were filled
    for (int k = 1023; k >= 0; k--) begin
      {page, idx} = 10'(k);
      read_ports(1'b0, page, idx);
      check_word("stm_pages", stm_model[{page, idx}], stm_rd_data);
    end
  endtask

  task automatic test_duty_bank();
    array_mem_pkg::bus_word_t readback;
    bus_write(2'd2, `ADDR_MOD_CYCLE, lfsr_word(), 2);
    bus_read(array_mem_pkg::bank_controller, `ADDR_MOD_CYCLE, readback);
    check_word("duty_bank", mod_cycle_model, readback);
    check_word("duty_bank", mod_cycle_model, mod_cycle);
    // Segment 1 and page 3 are still the selected write targets
    read_ports(1'b1, 2'd3, 8'h11);
    check_word("duty_bank", mod_model[{1'b1, 8'h11}], mod_rd_data);
    read_ports(1'b0, 2'd3, 8'h11);
    check_word("duty_bank", stm_model[{2'd3, 8'h11}], stm_rd_data);
  endtask

  task automatic test_long_write();
    array_mem_pkg::bus_word_t data;
    array_mem_pkg::bus_word_t readback;
    data = lfsr_word();
    // A second strobe during the held WE0 would store the changed data
    fork
      bus_write(array_mem_pkg::bank_controller, `ADDR_STM_CYCLE, data, 6);
      begin
        repeat (4) @(posedge CPU_CKIO);
        #2;
        cpu_data_in = ~data;
      end
    join
    bus_read(array_mem_pkg::bank_controller, `ADDR_STM_CYCLE, readback);
    check_word("long_write", data, readback);
    check_word("long_write", data, stm_cycle);
  endtask

  initial begin
    error_count    = 0;
    lfsr_state     = 32'h084c_6a38;
    rst_n          = 1'b0;
    cpu_addr       = '0;
    cpu_data_in    = '0;
    cpu_cs1_n      = 1'b1;
    cpu_we0_n      = 1'b1;
    mod_rd_segment = 1'b0;
    mod_rd_idx     = '0;
    stm_rd_segment = 1'b0;
    stm_rd_page    = '0;
    stm_rd_idx     = '0;
    repeat (10) @(posedge CPU_CKIO);
    #2;
    rst_n = 1'b1;
    test_reset_values();
    test_controller_regs();
    test_mod_segments();
    test_stm_pages();
    test_duty_bank();
    test_long_write();
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 2 * 20);
    $display("timeout: the tests did not finish within %0d clock cycles", TEST_CYCLES * 2);
    $display("test failed");
    $finish;
  end

endmodule
